// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/session_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module session_asserts (
    input logic                                 clk,
    input logic                                 rstN,
    input logic                                 cfg_valid,
    input logic                                 cfg_credit,
    input logic [bus_pkg::CREDIT_WIDTH-1:0]     credit_cnt,
    input logic [bus_pkg::MASTER_COUNT-1:0]     start
);
    import bus_pkg::*;

    credit_below_max: assert property (@(posedge clk) disable iff (!rstN)
        credit_cnt <= CREDIT_WIDTH'(CREDIT_MAX))
        else $error("credit count above CREDIT_MAX");

    // a word on the stream must own a credit
    valid_has_credit: assert property (@(posedge clk) disable iff (!rstN)
        cfg_valid |-> (credit_cnt != '0))
        else $error("cfg_valid high with no credit left");

    no_extra_credit: assert property (@(posedge clk) disable iff (!rstN)
        ((credit_cnt == CREDIT_WIDTH'(CREDIT_MAX)) && !cfg_valid) |-> !cfg_credit)
        else $error("credit returned beyond CREDIT_MAX");

    for (genvar m = 0; m < MASTER_COUNT; m++) begin : g_start
        start_one_cycle: assert property (@(posedge clk) disable iff (!rstN)
            start[m] |=> !start[m])
            else $error("start pulse longer than one cycle");
    end

endmodule

bind bus_session_ctrl session_asserts u_asserts (
    .clk, .rstN, .cfg_valid, .cfg_credit, .credit_cnt(u_emitter.credit_cnt), .start
);

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_top;
    import bus_pkg::*;

    localparam int WAIT_LIMIT = 400;  // cycles per wait
    localparam int SESSIONS   = 6;
    localparam int SEED       = 84;
    localparam int SECOND     = MASTER_COUNT - 1 - FIRST_START_MASTER;

    typedef struct packed {
        master_idx_t master;
        cfg_kind_t   kind;
        slave_id_t   slave;
        logic        rdwr;
        addr_t       addr;
        data_t       data;
    } cfg_word_t;

    logic                    clk;
    logic                    rstN;
    logic                    step;
    logic                    next_addr;
    data_t                   sw;
    logic [MASTER_COUNT-1:0] done;
    logic                    cfg_credit;
    logic                    cfg_valid;
    master_idx_t             cfg_master;
    cfg_kind_t               cfg_kind;
    slave_id_t               cfg_slave;
    logic                    cfg_rdwr;
    addr_t                   cfg_addr;
    data_t                   cfg_data;
    logic [MASTER_COUNT-1:0] start;
    logic                    idle_led;
    logic                    ready_led;
    logic                    busy_led;
    logic                    done_led;

    logic [31:0]             rng;
    logic [31:0]             credit_rng;
    int                      errors;
    int                      stream_errors;
    int                      cycle;
    int                      step_cycle;
    int                      seen_count;   // words seen on the stream
    int                      exp_count;    // words the model expects
    int                      returned;     // credits given back
    int                      gap;
    bit                      hold_credits;
    cfg_word_t               exp_log [1024];
    cfg_word_t               exp_w;
    int                      start_hits [MASTER_COUNT];
    int                      start_cycle [MASTER_COUNT];
    int                      hits_base [MASTER_COUNT];
    slave_id_t               sel_slave [MASTER_COUNT];
    logic [MASTER_COUNT-1:0] sel_rdwr;
    logic [MASTER_COUNT-1:0] sel_ext;
    addr_t                   first_a [MASTER_COUNT];
    addr_t                   len_a [MASTER_COUNT];
    data_t                   bank_vals [MASTER_COUNT][$];

    tb_clock u_clock (.clk);

    bus_session_ctrl UUT (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // last = first + length, kept inside the selected slave
    function automatic addr_t clamp_last(input slave_id_t id, input addr_t first, input addr_t len);
        int sum;
        int lim;
        sum = int'(first) + int'(len);
        lim = (id == '0) ? (1 << ADDR_WIDTH) - 1 : SLAVE_DEPTHS[int'(id) - 1] - 1;
        return addr_t'((sum > lim) ? lim : sum);
    endfunction

    function automatic bit watched(input int which);
        case (which)
            0:       return ready_led;
            1:       return done_led;
            default: return start_hits[SECOND] != hits_base[SECOND];
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int count);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h at cycle %0d", name, got, exp, cycle);
            count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for(input int which, input string what, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !ok; n++) begin
            next_cycle();
            ok = watched(which);
        end
        if (!ok) begin
            $display("timeout while waiting for %s", what);
            errors++;
        end
    endtask

    task automatic press_step(input data_t value);
        sw   = value;
        step = 1'b1;
        next_cycle();
        step = 1'b0;
    endtask

    task automatic enter_value(input data_t value);
        sw        = value;
        next_addr = 1'b1;
        next_cycle();
        next_addr = 1'b0;
    endtask

    task automatic apply_reset();
        rstN      = 1'b0;
        step      = 1'b0;
        next_addr = 1'b0;
        sw        = '0;
        done      = '0;
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
    endtask

    task automatic push_word(input int m, input cfg_kind_t kind, input addr_t addr, input data_t d);
        cfg_word_t w;
        w.master = master_idx_t'(m);
        w.kind   = kind;
        w.slave  = sel_slave[m];
        w.rdwr   = sel_rdwr[m];
        w.addr   = addr;
        w.data   = d;
        exp_log[exp_count] = w;
        exp_count++;
    endtask

    // masters in order, each as start, middles and last word
    task automatic build_expected();
        data_t list [$];
        addr_t last;
        for (int m = 0; m < MASTER_COUNT; m++) begin
            list = {};
            if (sel_ext[m] && (bank_vals[m].size() > 0)) begin
                list = bank_vals[m];
            end else begin
                list.push_back('0);
            end
            last = clamp_last(sel_slave[m], first_a[m], len_a[m]);
            push_word(m, CFG_START, first_a[m], list[0]);
            for (int i = 1; i < list.size() - 1; i++) begin
                push_word(m, CFG_MIDDLE, first_a[m], list[i]);
            end
            push_word(m, CFG_LAST, last, list[list.size() - 1]);
        end
    endtask

    task automatic run_session(input int idx, output bit ok);
        int n;
        int base;
        ok = 1'b1;
        apply_reset();
        check_value("cfg_valid", 32'(cfg_valid), 32'd0, errors);
        check_value("start", 32'(start), 32'd0, errors);
        check_value("idle_led", 32'(idle_led), 32'd1, errors);
        base      = seen_count;
        exp_count = seen_count;
        for (int m = 0; m < MASTER_COUNT; m++) begin
            rng          = xorshift32(rng);
            sel_slave[m] = rng[1:0];
            sel_rdwr[m]  = rng[2];
            sel_ext[m]   = rng[3];
            first_a[m]   = rng[15:4];
            len_a[m]     = rng[27:16] >> rng[31:30];
            bank_vals[m] = {};
            hits_base[m] = start_hits[m];
        end
        if (idx == 0) begin
            sel_slave[0] = '0;  // empty selection
            sel_slave[1] = '0;
        end else if (idx == 1) begin
            sel_slave[0] = 2'd3;  // 2000 + 300 runs past depth 2048
            first_a[0]   = 12'd2000;
            len_a[0]     = 12'd300;
            sel_ext[0]   = 1'b1;
        end
        press_step({12'd0, sel_slave[1], sel_slave[0]});
        if ((sel_slave[0] == '0) && (sel_slave[1] == '0)) begin
            wait_for(1, "done_led after empty selection", ok);
            check_value("words emitted", 32'(seen_count - base), 32'd0, errors);
            return;
        end
        press_step({14'd0, sel_rdwr});
        press_step({14'd0, sel_ext});
        for (int m = 0; m < MASTER_COUNT; m++) begin
            if (sel_ext[m]) begin
                rng = xorshift32(rng);
                n   = int'(rng % (BANK_DEPTH + 3));  // sometimes overfills the bank
                if ((idx == 1) && (n < CREDIT_MAX)) begin
                    n = CREDIT_MAX;  // list outlasts the credit window
                end
                for (int i = 0; i < n; i++) begin
                    rng = xorshift32(rng);
                    enter_value(rng[15:0]);
                    if (bank_vals[m].size() < BANK_DEPTH) begin
                        bank_vals[m].push_back(rng[15:0]);
                    end
                end
                press_step('0);
            end
        end
        for (int m = 0; m < MASTER_COUNT; m++) begin
            press_step(data_t'(first_a[m]));
        end
        build_expected();
        hold_credits = (idx == 1);
        for (int m = 0; m < MASTER_COUNT; m++) begin
            press_step(data_t'(len_a[m]));
        end
        if (hold_credits) begin
            repeat (20) next_cycle();
            check_value("words while credits held", 32'(seen_count - base), 32'(CREDIT_MAX),
                        errors);
            hold_credits = 1'b0;
        end
        wait_for(0, "ready_led", ok);
        if (!ok) begin
            return;
        end
        check_value("word count", 32'(seen_count), 32'(exp_count), errors);
        step_cycle = cycle;
        press_step('0);
        wait_for(2, "second start pulse", ok);
        if (!ok) begin
            return;
        end
        repeat (3) next_cycle();
        check_value("start first cycle", 32'(start_cycle[FIRST_START_MASTER]),
                    32'(step_cycle + 1), errors);
        check_value("start second cycle", 32'(start_cycle[SECOND]),
                    32'(step_cycle + 1 + COM_START_DELAY), errors);
        for (int m = 0; m < MASTER_COUNT; m++) begin
            check_value("start pulses", 32'(start_hits[m] - hits_base[m]), 32'd1, errors);
        end
        for (int m = 0; m < MASTER_COUNT; m++) begin
            if (sel_slave[m] != '0) begin
                repeat (3) next_cycle();
                check_value("done_led", 32'(done_led), 32'd0, errors);  // one master still busy
                check_value("busy_led", 32'(busy_led), 32'd1, errors);
                done[m] = 1'b1;
            end
        end
        wait_for(1, "done_led", ok);
        if (ok) begin
            check_value("busy_led", 32'(busy_led), 32'd0, errors);
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // stream monitor, compares each word with the model in order
    always @(negedge clk) begin
        if (rstN && cfg_valid) begin
            if (seen_count >= exp_count) begin
                $display("unexpected configuration word at cycle %0d", cycle);
                stream_errors++;
            end else begin
                exp_w = exp_log[seen_count];
                check_value("cfg_master", 32'(cfg_master), 32'(exp_w.master), stream_errors);
                check_value("cfg_kind", 32'(cfg_kind), 32'(exp_w.kind), stream_errors);
                check_value("cfg_slave", 32'(cfg_slave), 32'(exp_w.slave), stream_errors);
                check_value("cfg_rdwr", 32'(cfg_rdwr), 32'(exp_w.rdwr), stream_errors);
                check_value("cfg_addr", 32'(cfg_addr), 32'(exp_w.addr), stream_errors);
                check_value("cfg_data", 32'(cfg_data), 32'(exp_w.data), stream_errors);
            end
            seen_count++;
        end
        for (int m = 0; m < MASTER_COUNT; m++) begin
            if (start[m]) begin
                start_hits[m]++;
                start_cycle[m] = cycle;
            end
        end
    end

    // consumer hands credits back after random gaps
    initial begin
        bit give;
        cfg_credit = 1'b0;
        returned   = 0;
        gap        = 0;
        credit_rng = xorshift32(32'(SEED) ^ 32'h9e3779b9);
        forever begin
            @(posedge clk);
            give = 1'b0;
            if (!rstN) begin
                returned = seen_count;
                gap      = 0;
            end else if (gap > 0) begin
                gap--;
            end else if (!hold_credits && (returned < seen_count)) begin
                give       = 1'b1;
                returned++;
                credit_rng = xorshift32(credit_rng);
                gap        = int'(credit_rng % 3);
            end
            #1;
            cfg_credit = give;
        end
    end

    initial begin
        bit ok;
        rstN         = 1'b0;
        step         = 1'b0;
        next_addr    = 1'b0;
        sw           = '0;
        done         = '0;
        hold_credits = 1'b0;
        errors       = 0;
        rng          = 32'(SEED);
        ok           = 1'b1;
        for (int s = 0; s < SESSIONS && ok; s++) begin
            run_session(s, ok);
        end
        repeat (2) next_cycle();
        $display("errors: %0d checks, %0d stream", errors, stream_errors);
        if ((errors == 0) && (stream_errors == 0)) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/addr_range.sv ====
`timescale 1ns/100ps
`default_nettype none

module addr_range (
    input  logic                             clk,
    input  logic                             rstN,
    input  bus_pkg::data_t                   sw,
    input  logic                             range_load,
    input  bus_pkg::range_field_t            range_field,
    input  bus_pkg::master_idx_t             rd_master,
    output bus_pkg::slave_id_t               slave,
    output logic                             rdwr,
    output logic [bus_pkg::MASTER_COUNT-1:0] ext,
    output bus_pkg::addr_t                   first_addr,
    output bus_pkg::addr_t                   last_addr
);
    import bus_pkg::*;

    slave_id_t               slave_q [MASTER_COUNT];
    logic [MASTER_COUNT-1:0] rdwr_q;
    addr_t                   first_q [MASTER_COUNT];
    addr_t                   last_q  [MASTER_COUNT];
    master_idx_t             fld_m;  // master addressed by the entry
    logic [ADDR_WIDTH:0]     sum;    // carry kept for the clamp compare
    addr_t                   limit;

    function automatic addr_t depth_limit(slave_id_t id);
        if (id == '0) begin
            return '1;
        end
        return addr_t'(SLAVE_DEPTHS[id - 1'b1] - 1);
    endfunction

    assign fld_m = ((range_field == RF_FIRST_M1) || (range_field == RF_LEN_M1)) ?
                   master_idx_t'(1) : master_idx_t'(0);
    assign sum   = {1'b0, first_q[fld_m]} + {1'b0, sw[ADDR_WIDTH-1:0]};
    assign limit = depth_limit(slave_q[fld_m]);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slave_q <= '{default: '0};
            rdwr_q  <= '0;
            ext     <= '0;
            first_q <= '{default: '0};
            last_q  <= '{default: '0};
        end else if (range_load) begin
            case (range_field)
                RF_SLAVE: begin
                    for (int m = 0; m < MASTER_COUNT; m++) begin
                        slave_q[m] <= sw[2*m +: 2];
                    end
                end
                RF_RDWR:                  rdwr_q <= sw[MASTER_COUNT-1:0];
                RF_EXT:                   ext <= sw[MASTER_COUNT-1:0];
                RF_FIRST_M0, RF_FIRST_M1: first_q[fld_m] <= sw[ADDR_WIDTH-1:0];
                default:                  last_q[fld_m] <= (sum > {1'b0, limit}) ?
                                                           limit : sum[ADDR_WIDTH-1:0];
            endcase
        end
    end

    assign slave      = slave_q[rd_master];
    assign rdwr       = rdwr_q[rd_master];
    assign first_addr = first_q[rd_master];
    assign last_addr  = last_q[rd_master];

endmodule

`default_nettype wire

// ==== rtl/bank_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface bank_if;
    import bus_pkg::*;

    logic        wr_en;      // store sw at the write master's count
    master_idx_t wr_master;
    master_idx_t rd_master;
    bank_idx_t   rd_idx;
    data_t       rd_data;
    bank_cnt_t   count;      // stored values of rd_master

    modport fsm (
        output wr_en,
        output wr_master,
        output rd_master,
        output rd_idx,
        input  rd_data,
        input  count
    );

    modport mem (
        input  wr_en,
        input  wr_master,
        input  rd_master,
        input  rd_idx,
        output rd_data,
        output count
    );

endinterface

`default_nettype wire

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    localparam int DATA_WIDTH         = 16;
    localparam int MASTER_COUNT       = 2;
    localparam int SLAVE_COUNT        = 3;  // ids 1..3, id 0 means no slave
    localparam int SLAVE_DEPTHS [SLAVE_COUNT] = '{4096, 4096, 2048};
    localparam int BANK_DEPTH         = 16;
    localparam int CREDIT_MAX         = 4;
    localparam int COM_START_DELAY    = 5;  // timer needs at least 2
    localparam int FIRST_START_MASTER = 0;

    // deepest slave sets the master address width
    function automatic int max_depth();
        int m;
        m = 0;
        foreach (SLAVE_DEPTHS[i]) begin
            if (SLAVE_DEPTHS[i] > m) begin
                m = SLAVE_DEPTHS[i];
            end
        end
        return m;
    endfunction

    localparam int ADDR_WIDTH   = $clog2(max_depth());
    localparam int CREDIT_WIDTH = $clog2(CREDIT_MAX + 1);
    localparam int DELAY_WIDTH  = $clog2(COM_START_DELAY);

    typedef enum logic [3:0] {
        SEL_SLAVE, SEL_RDWR, SEL_EXT, WRITE_M0, WRITE_M1, FIRST_M0, FIRST_M1,
        LEN_M0, LEN_M1, CONFIG, READY, COMM, DONE
    } session_state_t;

    typedef enum logic [1:0] {CFG_START, CFG_MIDDLE, CFG_LAST} cfg_kind_t;

    // which operator entry addr_range captures from the switch word
    typedef enum logic [2:0] {
        RF_SLAVE, RF_RDWR, RF_EXT, RF_FIRST_M0, RF_FIRST_M1, RF_LEN_M0, RF_LEN_M1
    } range_field_t;

    typedef logic [$clog2(SLAVE_COUNT + 1)-1:0] slave_id_t;
    typedef logic [ADDR_WIDTH-1:0]              addr_t;
    typedef logic [DATA_WIDTH-1:0]              data_t;
    typedef logic [$clog2(MASTER_COUNT)-1:0]    master_idx_t;
    typedef logic [$clog2(BANK_DEPTH)-1:0]      bank_idx_t;
    typedef logic [$clog2(BANK_DEPTH):0]        bank_cnt_t;  // reaches BANK_DEPTH itself

endpackage

`default_nettype wire

// ==== rtl/bus_session_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_session_ctrl (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             step,
    input  logic                             next_addr,
    input  bus_pkg::data_t                   sw,
    input  logic [bus_pkg::MASTER_COUNT-1:0] done,
    input  logic                             cfg_credit,
    output logic                             cfg_valid,
    output bus_pkg::master_idx_t             cfg_master,
    output bus_pkg::cfg_kind_t               cfg_kind,
    output bus_pkg::slave_id_t               cfg_slave,
    output logic                             cfg_rdwr,
    output bus_pkg::addr_t                   cfg_addr,
    output bus_pkg::data_t                   cfg_data,
    output logic [bus_pkg::MASTER_COUNT-1:0] start,
    output logic                             idle_led,
    output logic                             ready_led,
    output logic                             busy_led,
    output logic                             done_led
);
    import bus_pkg::*;

    bank_if bank ();

    session_state_t          state;
    logic                    word_take;
    logic                    word_go;
    master_idx_t             word_master;
    cfg_kind_t               word_kind;
    data_t                   word_data;
    logic                    range_load;
    range_field_t            range_field;
    logic                    timer_fire;
    slave_id_t               slave;
    logic                    rdwr;
    logic [MASTER_COUNT-1:0] ext;
    addr_t                   first_addr;
    addr_t                   last_addr;

    session_fsm u_fsm (
        .clk, .rstN, .step, .next_addr, .sw, .done, .bank, .ext,
        .word_go, .word_take, .word_master, .word_kind, .word_data,
        .range_load, .range_field, .start_go(start), .timer_fire, .state
    );

    start_timer u_timer (.clk, .rstN, .arm(start[FIRST_START_MASTER]), .fire(timer_fire));

    data_bank u_bank (.clk, .rstN, .sw, .bank);

    addr_range u_range (
        .clk, .rstN, .sw, .range_load, .range_field, .rd_master(bank.rd_master),
        .slave, .rdwr, .ext, .first_addr, .last_addr
    );

    cfg_emitter u_emitter (
        .clk, .rstN, .word_take, .word_master, .word_kind, .word_slave(slave),
        .word_rdwr(rdwr), .word_first(first_addr), .word_last(last_addr), .word_data,
        .word_go, .cfg_credit, .cfg_valid, .cfg_master, .cfg_kind, .cfg_slave,
        .cfg_rdwr, .cfg_addr, .cfg_data
    );

    assign idle_led  = (state == SEL_SLAVE);
    assign ready_led = (state == READY);  // configuration finished, waiting for start
    assign busy_led  = (state == COMM);
    assign done_led  = (state == DONE);

endmodule

`default_nettype wire

// ==== rtl/cfg_emitter.sv ====
`timescale 1ns/100ps
`default_nettype none

module cfg_emitter (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 word_take,
    input  bus_pkg::master_idx_t word_master,
    input  bus_pkg::cfg_kind_t   word_kind,
    input  bus_pkg::slave_id_t   word_slave,
    input  logic                 word_rdwr,
    input  bus_pkg::addr_t       word_first,
    input  bus_pkg::addr_t       word_last,
    input  bus_pkg::data_t       word_data,
    output logic                 word_go,
    input  logic                 cfg_credit,
    output logic                 cfg_valid,
    output bus_pkg::master_idx_t cfg_master,
    output bus_pkg::cfg_kind_t   cfg_kind,
    output bus_pkg::slave_id_t   cfg_slave,
    output logic                 cfg_rdwr,
    output bus_pkg::addr_t       cfg_addr,
    output bus_pkg::data_t       cfg_data
);
    import bus_pkg::*;

    logic [CREDIT_WIDTH-1:0] credit_cnt;

    // the word on the stream now still holds its credit,
    // so the next one needs a spare
    assign word_go = word_take && (credit_cnt > CREDIT_WIDTH'(cfg_valid));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credit_cnt <= CREDIT_WIDTH'(CREDIT_MAX);
            cfg_valid  <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt - CREDIT_WIDTH'(cfg_valid) + CREDIT_WIDTH'(cfg_credit);
            cfg_valid  <= word_go;  // one cycle per granted word
        end
    end

    always_ff @(posedge clk) begin
        if (word_go) begin
            cfg_master <= word_master;
            cfg_kind   <= word_kind;
            cfg_slave  <= word_slave;
            cfg_rdwr   <= word_rdwr;
            cfg_addr   <= (word_kind == CFG_LAST) ? word_last : word_first;
            cfg_data   <= word_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/data_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_bank (
    input  logic           clk,
    input  logic           rstN,
    input  bus_pkg::data_t sw,
    bank_if.mem            bank
);
    import bus_pkg::*;

    data_t     mem [MASTER_COUNT][BANK_DEPTH];
    bank_cnt_t cnt [MASTER_COUNT];
    logic      wr_ok;

    // a full bank ignores further entries
    assign wr_ok = bank.wr_en && (cnt[bank.wr_master] < bank_cnt_t'(BANK_DEPTH));

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[bank.wr_master][bank_idx_t'(cnt[bank.wr_master])] <= sw;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt <= '{default: '0};
        end else if (wr_ok) begin
            cnt[bank.wr_master] <= cnt[bank.wr_master] + 1'b1;
        end
    end

    assign bank.rd_data = mem[bank.rd_master][bank.rd_idx];  // async read
    assign bank.count   = cnt[bank.rd_master];

endmodule

`default_nettype wire

// ==== rtl/session_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module session_fsm (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               step,
    input  logic                               next_addr,
    input  bus_pkg::data_t                     sw,
    input  logic [bus_pkg::MASTER_COUNT-1:0]   done,
    bank_if.fsm                                bank,
    input  logic [bus_pkg::MASTER_COUNT-1:0]   ext,
    input  logic                               word_go,
    output logic                               word_take,
    output bus_pkg::master_idx_t               word_master,
    output bus_pkg::cfg_kind_t                 word_kind,
    output bus_pkg::data_t                     word_data,
    output logic                               range_load,
    output bus_pkg::range_field_t              range_field,
    output logic [bus_pkg::MASTER_COUNT-1:0]   start_go,
    input  logic                               timer_fire,
    output bus_pkg::session_state_t            state
);
    import bus_pkg::*;

    session_state_t          state_next;
    master_idx_t             cur_master;  // master being configured
    cfg_kind_t               cur_kind;
    bank_idx_t               mid_idx;     // list element of the next middle word
    logic                    drain;       // final word is on the stream
    logic [MASTER_COUNT-1:0] active;      // masters with a slave selected
    logic                    use_list;

    assign use_list    = ext[cur_master] && (bank.count != '0);
    assign word_take   = (state == CONFIG) && !drain;
    assign word_master = cur_master;
    assign word_kind   = cur_kind;
    assign word_data   = use_list ? bank.rd_data : '0;  // no list sends a single zero

    assign bank.wr_en     = next_addr && ((state == WRITE_M0) || (state == WRITE_M1));
    assign bank.wr_master = (state == WRITE_M1) ? master_idx_t'(1) : master_idx_t'(0);
    assign bank.rd_master = cur_master;

    always_comb begin
        case (cur_kind)
            CFG_START:  bank.rd_idx = '0;
            CFG_MIDDLE: bank.rd_idx = mid_idx;
            default:    bank.rd_idx = bank_idx_t'(bank.count - 1'b1);
        endcase
    end

    // each menu state hands its switch entry to addr_range on the step
    always_comb begin
        range_load = step;
        case (state)
            SEL_SLAVE: range_field = RF_SLAVE;
            SEL_RDWR:  range_field = RF_RDWR;
            SEL_EXT:   range_field = RF_EXT;
            FIRST_M0:  range_field = RF_FIRST_M0;
            FIRST_M1:  range_field = RF_FIRST_M1;
            LEN_M0:    range_field = RF_LEN_M0;
            LEN_M1:    range_field = RF_LEN_M1;
            default: begin
                range_field = RF_SLAVE;
                range_load  = 1'b0;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            SEL_SLAVE: if (step) state_next = (sw[3:0] == '0) ? DONE : SEL_RDWR;
            SEL_RDWR:  if (step) state_next = SEL_EXT;
            SEL_EXT: begin
                if (step) begin
                    if (sw[0]) state_next = WRITE_M0;
                    else if (sw[1]) state_next = WRITE_M1;
                    else state_next = FIRST_M0;
                end
            end
            WRITE_M0:  if (step) state_next = ext[1] ? WRITE_M1 : FIRST_M0;
            WRITE_M1:  if (step) state_next = FIRST_M0;
            FIRST_M0:  if (step) state_next = FIRST_M1;
            FIRST_M1:  if (step) state_next = LEN_M0;
            LEN_M0:    if (step) state_next = LEN_M1;
            LEN_M1:    if (step) state_next = CONFIG;
            CONFIG:    if (drain) state_next = READY;
            READY:     if (step) state_next = COMM;
            COMM:      if (&(done | ~active)) state_next = DONE;  // idle masters never finish
            default:   state_next = state;  // DONE waits for reset
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= SEL_SLAVE;
            cur_master <= '0;
            cur_kind   <= CFG_START;
            mid_idx    <= '0;
            drain      <= 1'b0;
            active     <= '0;
            start_go   <= '0;
        end else begin
            state    <= state_next;
            start_go <= '0;
            if ((state == SEL_SLAVE) && step) begin
                for (int m = 0; m < MASTER_COUNT; m++) begin
                    active[m] <= |sw[2*m +: 2];
                end
            end
            if ((state == READY) && step) begin
                start_go[FIRST_START_MASTER] <= 1'b1;  // also arms the timer
            end
            if (timer_fire) begin
                start_go[MASTER_COUNT-1-FIRST_START_MASTER] <= 1'b1;
            end
            if (word_go) begin
                case (cur_kind)
                    CFG_START: begin
                        if (use_list && (bank.count > bank_cnt_t'(2))) begin
                            cur_kind <= CFG_MIDDLE;
                            mid_idx  <= bank_idx_t'(1);
                        end else begin
                            cur_kind <= CFG_LAST;
                        end
                    end
                    CFG_MIDDLE: begin
                        if (bank_cnt_t'(mid_idx) + bank_cnt_t'(2) == bank.count) begin
                            cur_kind <= CFG_LAST;
                        end
                        mid_idx <= mid_idx + 1'b1;
                    end
                    default: begin
                        cur_kind <= CFG_START;
                        if (cur_master == master_idx_t'(MASTER_COUNT - 1)) begin
                            drain <= 1'b1;
                        end else begin
                            cur_master <= cur_master + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/start_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module start_timer (
    input  logic clk,
    input  logic rstN,
    input  logic arm,
    output logic fire
);
    import bus_pkg::*;

    logic                   busy;
    logic [DELAY_WIDTH-1:0] cnt;

    // arm comes one cycle after the step and the start pulse is registered
    // behind fire, so fire lands two cycles short of the full gap
    assign fire = busy && (cnt == DELAY_WIDTH'(COM_START_DELAY - 2));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (arm) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (fire) begin
            busy <= 1'b0;  // single pulse per arm
        end else if (busy) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/bus_pkg.sv
rtl/bank_if.sv
rtl/session_fsm.sv
rtl/start_timer.sv
rtl/data_bank.sv
rtl/addr_range.sv
rtl/cfg_emitter.sv
rtl/bus_session_ctrl.sv
dv/tb_clock.sv
dv/session_asserts.sv
dv/tb_top.sv
